//--- include/bp_settings.svh
`ifndef BP_SETTINGS_SVH
`define BP_SETTINGS_SVH

// one signed fixed-point value
`define BP_DATA_W     16
`define BP_FRAC_BITS  8

// lanes per row, also rows per layer
`define BP_SIZE       3
`define BP_MAX_LAYERS 4

// read request to weight update output
`define BP_LATENCY    3

`endif

//--- rtl/bp_pkg.sv
`default_nettype none

`include "bp_settings.svh"

package bp_pkg;

    typedef logic signed [`BP_DATA_W-1:0] fixed_t;

    // lane 0 sits in the top bits
    typedef logic [`BP_DATA_W*`BP_SIZE-1:0] row_t;

    typedef logic [$clog2(`BP_MAX_LAYERS)-1:0] layer_idx_t;
    typedef logic [$clog2(`BP_SIZE)-1:0]       row_idx_t;

    typedef enum logic {
        IDLE,
        SWEEP
    } seq_state_t;

    typedef struct packed {
        logic       en;
        layer_idx_t layer;
        row_idx_t   row;
        row_t       start_row;
        row_t       act_row;
    } store_req_t;

    typedef struct packed {
        logic       valid;
        layer_idx_t layer;
        row_idx_t   row;
    } read_tag_t;

    typedef struct packed {
        read_tag_t                tag;
        row_t [`BP_SIZE-1:0]      chain;
        row_t                     start_row;
    } chain_stage_t;

    typedef struct packed {
        read_tag_t tag;
        row_t      grad;
    } weight_update_t;

    // Q8.8 product, arithmetic shift then truncate
    function automatic fixed_t fx_mul(input fixed_t a, input fixed_t b);
        logic signed [2*`BP_DATA_W-1:0] prod;
        logic signed [2*`BP_DATA_W-1:0] scaled;
        prod = a * b;
        scaled = prod >>> `BP_FRAC_BITS;
        return scaled[`BP_DATA_W-1:0];
    endfunction

    // plain wrap, no saturation
    function automatic fixed_t fx_add(input fixed_t a, input fixed_t b);
        return a + b;
    endfunction

endpackage

`default_nettype wire

//--- rtl/update_sequencer.sv
`default_nettype none

`include "bp_settings.svh"

module update_sequencer (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               active_train_i,
    input  logic               read_update_data_i,
    input  bp_pkg::layer_idx_t current_input_layer_i,
    input  bp_pkg::row_idx_t   current_input_row_i,
    input  bp_pkg::row_t       diff_start_i,
    input  bp_pkg::row_t       diff_act_i,
    output bp_pkg::store_req_t store_req_o,
    output bp_pkg::read_tag_t  read_tag_o
);
    import bp_pkg::*;

    seq_state_t state_q;
    seq_state_t state_d;
    layer_idx_t layer_cnt_q;
    row_idx_t   row_cnt_q;
    logic       last_row;
    logic       last_layer;

    assign last_row   = (row_cnt_q == row_idx_t'(`BP_SIZE - 1));
    assign last_layer = (layer_cnt_q == layer_idx_t'(`BP_MAX_LAYERS - 1));

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (read_update_data_i) begin
                    state_d = SWEEP;
                end
            end
            SWEEP: begin
                if (!read_update_data_i) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // row counts fastest, then layer, wrapping after the last pair
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q     <= IDLE;
            layer_cnt_q <= '0;
            row_cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            if (read_update_data_i) begin
                if (last_row) begin
                    row_cnt_q   <= '0;
                    layer_cnt_q <= last_layer ? '0 : layer_cnt_q + 1'b1;
                end else begin
                    row_cnt_q <= row_cnt_q + 1'b1;
                end
            end else if (state_q == SWEEP) begin
                // sweep ended, next one starts at the first pair
                row_cnt_q   <= '0;
                layer_cnt_q <= '0;
            end
        end
    end

    // training writes are locked out during readout
    assign store_req_o.en        = active_train_i && !read_update_data_i;
    assign store_req_o.layer     = current_input_layer_i;
    assign store_req_o.row       = current_input_row_i;
    assign store_req_o.start_row = diff_start_i;
    assign store_req_o.act_row   = diff_act_i;

    assign read_tag_o.valid = read_update_data_i;
    assign read_tag_o.layer = layer_cnt_q;
    assign read_tag_o.row   = row_cnt_q;

endmodule

`default_nettype wire

//--- rtl/cost_store.sv
`default_nettype none

`include "bp_settings.svh"

module cost_store (
    input  logic                         clk,
    input  logic                         reset_i,
    input  logic                         is_last_layer_i,
    input  bp_pkg::row_idx_t             current_input_row_i,
    input  bp_pkg::row_t                 diff_cost_i,
    output bp_pkg::row_t [`BP_SIZE-1:0]  cost_rows_o
);
    import bp_pkg::*;

    row_t [`BP_SIZE-1:0] cost_q;
    logic                row_in_range;

    // row index field is wider than the row count
    assign row_in_range = (current_input_row_i < row_idx_t'(`BP_SIZE));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cost_q <= '0;
        end else if (is_last_layer_i && row_in_range) begin
            cost_q[current_input_row_i] <= diff_cost_i;
        end
    end

    // all cost rows visible at once
    assign cost_rows_o = cost_q;

endmodule

`default_nettype wire

//--- rtl/start_store.sv
`default_nettype none

`include "bp_settings.svh"

module start_store (
    input  logic                         clk,
    input  logic                         reset_i,
    input  bp_pkg::store_req_t           store_req_i,
    input  bp_pkg::read_tag_t            read_tag_i,
    output bp_pkg::read_tag_t            read_tag_o,
    output bp_pkg::row_t [`BP_SIZE-1:0]  act_rows_o,
    output bp_pkg::row_t                 start_row_o
);
    import bp_pkg::*;

    // one entry per layer, each holding every row of that layer
    row_t [`BP_SIZE-1:0] start_mem [`BP_MAX_LAYERS];
    row_t [`BP_SIZE-1:0] act_mem   [`BP_MAX_LAYERS];

    read_tag_t           tag_q;
    row_t [`BP_SIZE-1:0] act_rows_q;
    row_t                start_row_q;
    logic                wr_row_ok;

    assign wr_row_ok = (store_req_i.row < row_idx_t'(`BP_SIZE));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int l = 0; l < `BP_MAX_LAYERS; l++) begin
                start_mem[l] <= '0;
                act_mem[l]   <= '0;
            end
        end else if (store_req_i.en && wr_row_ok) begin
            start_mem[store_req_i.layer][store_req_i.row] <= store_req_i.start_row;
            act_mem[store_req_i.layer][store_req_i.row]   <= store_req_i.act_row;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            tag_q <= '0;
        end else begin
            tag_q <= read_tag_i;
        end
    end

    // registered read, whole activation layer plus one start row
    always_ff @(posedge clk) begin
        act_rows_q  <= act_mem[read_tag_i.layer];
        start_row_q <= start_mem[read_tag_i.layer][read_tag_i.row];
    end

    assign read_tag_o  = tag_q;
    assign act_rows_o  = act_rows_q;
    assign start_row_o = start_row_q;

endmodule

`default_nettype wire

//--- rtl/chain_multiplier.sv
`default_nettype none

`include "bp_settings.svh"

module chain_multiplier (
    input  logic                         clk,
    input  logic                         reset_i,
    input  bp_pkg::read_tag_t            read_tag_i,
    input  bp_pkg::row_t [`BP_SIZE-1:0]  cost_rows_i,
    input  bp_pkg::row_t [`BP_SIZE-1:0]  act_rows_i,
    input  bp_pkg::row_t                 start_row_i,
    output bp_pkg::chain_stage_t         chain_o
);
    import bp_pkg::*;

    row_t [`BP_SIZE-1:0] chain_d;
    chain_stage_t        chain_q;

    // chain row k, lane j is cost(k, j) times act(k, j)
    always_comb begin
        for (int k = 0; k < `BP_SIZE; k++) begin
            for (int j = 0; j < `BP_SIZE; j++) begin
                chain_d[k][`BP_DATA_W*(`BP_SIZE-j)-1 -: `BP_DATA_W] = fx_mul(
                    cost_rows_i[k][`BP_DATA_W*(`BP_SIZE-j)-1 -: `BP_DATA_W],
                    act_rows_i[k][`BP_DATA_W*(`BP_SIZE-j)-1 -: `BP_DATA_W]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            chain_q.tag <= '0;
        end else begin
            chain_q.tag <= read_tag_i;
        end
    end

    always_ff @(posedge clk) begin
        chain_q.chain     <= chain_d;
        chain_q.start_row <= start_row_i;
    end

    assign chain_o = chain_q;

endmodule

`default_nettype wire

//--- rtl/gradient_accumulator.sv
`default_nettype none

`include "bp_settings.svh"

module gradient_accumulator (
    input  logic                   clk,
    input  logic                   reset_i,
    input  bp_pkg::chain_stage_t   chain_i,
    output bp_pkg::weight_update_t update_o
);
    import bp_pkg::*;

    row_t           grad_d;
    weight_update_t update_q;

    // lane j sums chain(k, j) weighted by start lane k
    always_comb begin
        fixed_t acc;
        fixed_t term;
        grad_d = '0;
        for (int j = 0; j < `BP_SIZE; j++) begin
            acc = '0;
            for (int k = 0; k < `BP_SIZE; k++) begin
                term = fx_mul(
                    chain_i.chain[k][`BP_DATA_W*(`BP_SIZE-j)-1 -: `BP_DATA_W],
                    chain_i.start_row[`BP_DATA_W*(`BP_SIZE-k)-1 -: `BP_DATA_W]);
                acc = fx_add(acc, term);
            end
            grad_d[`BP_DATA_W*(`BP_SIZE-j)-1 -: `BP_DATA_W] = acc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            update_q.tag <= '0;
        end else begin
            update_q.tag <= chain_i.tag;
        end
    end

    // gradient payload follows the tag
    always_ff @(posedge clk) begin
        update_q.grad <= grad_d;
    end

    assign update_o = update_q;

endmodule

`default_nettype wire

//--- rtl/backprop_stack.sv
`default_nettype none

`include "bp_settings.svh"

module backprop_stack (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               active_train_i,
    input  logic               read_update_data_i,
    input  logic               is_last_layer_i,
    input  bp_pkg::layer_idx_t current_input_layer_i,
    input  bp_pkg::row_idx_t   current_input_row_i,
    input  bp_pkg::row_t       diff_start_i,
    input  bp_pkg::row_t       diff_act_i,
    input  bp_pkg::row_t       diff_cost_i,
    output logic               is_update_weight_o,
    output bp_pkg::layer_idx_t update_weight_layer_o,
    output bp_pkg::row_idx_t   update_weight_row_o,
    output bp_pkg::row_t       update_weight_value_o
);
    import bp_pkg::*;

    store_req_t          store_req;
    read_tag_t           seq_tag;
    read_tag_t           mem_tag;
    row_t [`BP_SIZE-1:0] cost_rows;
    row_t [`BP_SIZE-1:0] act_rows;
    row_t                start_row;
    chain_stage_t        chain;
    weight_update_t      update;

    update_sequencer u_sequencer (
        .clk                   (clk),
        .reset_i               (reset_i),
        .active_train_i        (active_train_i),
        .read_update_data_i    (read_update_data_i),
        .current_input_layer_i (current_input_layer_i),
        .current_input_row_i   (current_input_row_i),
        .diff_start_i          (diff_start_i),
        .diff_act_i            (diff_act_i),
        .store_req_o           (store_req),
        .read_tag_o            (seq_tag)
    );

    cost_store u_cost_store (
        .clk                 (clk),
        .reset_i             (reset_i),
        .is_last_layer_i     (is_last_layer_i),
        .current_input_row_i (current_input_row_i),
        .diff_cost_i         (diff_cost_i),
        .cost_rows_o         (cost_rows)
    );

    // pipeline stage 1, memory read
    start_store u_start_store (
        .clk         (clk),
        .reset_i     (reset_i),
        .store_req_i (store_req),
        .read_tag_i  (seq_tag),
        .read_tag_o  (mem_tag),
        .act_rows_o  (act_rows),
        .start_row_o (start_row)
    );

    // stage 2, cost times activation
    chain_multiplier u_chain_mult (
        .clk         (clk),
        .reset_i     (reset_i),
        .read_tag_i  (mem_tag),
        .cost_rows_i (cost_rows),
        .act_rows_i  (act_rows),
        .start_row_i (start_row),
        .chain_o     (chain)
    );

    // stage 3, weighted sum into the gradient row
    gradient_accumulator u_grad_acc (
        .clk      (clk),
        .reset_i  (reset_i),
        .chain_i  (chain),
        .update_o (update)
    );

    assign is_update_weight_o    = update.tag.valid;
    assign update_weight_layer_o = update.tag.layer;
    assign update_weight_row_o   = update.tag.row;
    assign update_weight_value_o = update.grad;

endmodule

`default_nettype wire

//--- tests/bp_clock_gen.sv
`default_nettype none

module bp_clock_gen (
    output logic clk,
    output logic reset_o
);
    localparam int HALF_PERIOD = 50;
    localparam int RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // release on a rising edge so the falling-edge driver sees a settled level
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_o <= 1'b0;
    end

endmodule

`default_nettype wire

//--- tests/backprop_stack_tb.sv
`default_nettype none

`include "bp_settings.svh"

module backprop_stack_tb;
    import bp_pkg::*;

    typedef struct packed {
        logic [3:0] test;
        logic       train;
        logic       read;
        logic       last;
        layer_idx_t layer;
        row_idx_t   row;
        row_t       start_row;
        row_t       act_row;
        row_t       cost_row;
    } stim_t;

    typedef struct packed {
        logic [3:0] test;
        logic       valid;
        layer_idx_t layer;
        row_idx_t   row;
        row_t       grad;
    } expect_t;

    logic       clk;
    logic       reset_i;
    logic       active_train;
    logic       read_update_data;
    logic       is_last_layer;
    layer_idx_t current_input_layer;
    row_idx_t   current_input_row;
    row_t       diff_start;
    row_t       diff_act;
    row_t       diff_cost;
    logic       is_update_weight;
    layer_idx_t update_weight_layer;
    row_idx_t   update_weight_row;
    row_t       update_weight_value;

    stim_t      stim_q[$];
    expect_t    pending_q[$];
    // shadow copies of the DUT memories
    row_t       m_cost [`BP_SIZE];
    row_t       m_start [`BP_MAX_LAYERS][`BP_SIZE];
    row_t       m_act [`BP_MAX_LAYERS][`BP_SIZE];
    row_t       gen_start [`BP_MAX_LAYERS][`BP_SIZE];
    layer_idx_t m_layer;
    row_idx_t   m_row;
    integer     seed = 16;
    int         errors = 0;
    int         checks = 0;
    int         test_errors = 0;
    int         cur_test = 1;
    int         cycles = 0;
    int         cycle_limit = 1000;
    string      test_name [1:5];

    bp_clock_gen clock_gen (
        .clk     (clk),
        .reset_o (reset_i)
    );

    backprop_stack uut (
        .clk                   (clk),
        .reset_i               (reset_i),
        .active_train_i        (active_train),
        .read_update_data_i    (read_update_data),
        .is_last_layer_i       (is_last_layer),
        .current_input_layer_i (current_input_layer),
        .current_input_row_i   (current_input_row),
        .diff_start_i          (diff_start),
        .diff_act_i            (diff_act),
        .diff_cost_i           (diff_cost),
        .is_update_weight_o    (is_update_weight),
        .update_weight_layer_o (update_weight_layer),
        .update_weight_row_o   (update_weight_row),
        .update_weight_value_o (update_weight_value)
    );

    // lane 0 is the most significant value
    function automatic fixed_t lane_of(input row_t r, input int j);
        return r[`BP_DATA_W*(`BP_SIZE-j)-1 -: `BP_DATA_W];
    endfunction

    // Q8.8 product keeps the low 16 bits after an arithmetic shift
    function automatic fixed_t q88_product(input fixed_t a, input fixed_t b);
        int full;
        full = int'(a) * int'(b);
        return fixed_t'(full >>> `BP_FRAC_BITS);
    endfunction

    // signed lanes within about plus or minus one
    function automatic row_t random_row();
        row_t        r;
        logic [31:0] v;
        for (int j = 0; j < `BP_SIZE; j++) begin
            v = $random(seed);
            r[`BP_DATA_W*(`BP_SIZE-j)-1 -: `BP_DATA_W] = {{7{v[8]}}, v[8:0]};
        end
        return r;
    endfunction

    function automatic row_t model_grad(input layer_idx_t l, input row_idx_t r);
        row_t   g;
        fixed_t acc;
        fixed_t chain_term;
        g = '0;
        for (int j = 0; j < `BP_SIZE; j++) begin
            acc = '0;
            for (int k = 0; k < `BP_SIZE; k++) begin
                chain_term = q88_product(lane_of(m_cost[k], j), lane_of(m_act[l][k], j));
                acc = acc + q88_product(chain_term, lane_of(m_start[l][r], k));
            end
            g[`BP_DATA_W*(`BP_SIZE-j)-1 -: `BP_DATA_W] = acc;
        end
        return g;
    endfunction

    task automatic add_entry(input int test, input logic train, input logic read,
                             input logic last, input int layer, input int row,
                             input row_t start_row, input row_t act_row, input row_t cost_row);
        stim_t s;
        s.test      = 4'(test);
        s.train     = train;
        s.read      = read;
        s.last      = last;
        s.layer     = layer_idx_t'(layer);
        s.row       = row_idx_t'(row);
        s.start_row = start_row;
        s.act_row   = act_row;
        s.cost_row  = cost_row;
        stim_q.push_back(s);
    endtask

    task automatic add_idle(input int test, input int n);
        repeat (n) add_entry(test, 1'b0, 1'b0, 1'b0, 0, 0, '0, '0, '0);
    endtask

    // junk stores ride along when requested and must be ignored
    task automatic add_sweep(input int test, input int n, input logic junk);
        for (int i = 0; i < n; i++) begin
            add_entry(test, junk, 1'b1, 1'b0, i % 4, i % 3,
                      junk ? random_row() : '0, junk ? random_row() : '0, '0);
        end
    endtask

    task automatic build_stimulus();
        add_idle(1, 5);
        // cost rows go in with layer 0
        for (int l = 0; l < `BP_MAX_LAYERS; l++) begin
            for (int r = 0; r < `BP_SIZE; r++) begin
                gen_start[l][r] = random_row();
                add_entry(2, 1'b1, 1'b0, l == 0, l, r, gen_start[l][r],
                          random_row(), random_row());
            end
        end
        add_sweep(2, 12, 1'b0);
        add_idle(2, 3);
        add_sweep(3, 12, 1'b1);
        add_idle(3, 3);
        add_sweep(4, 16, 1'b0);
        add_idle(4, 2);
        add_sweep(4, 5, 1'b0);
        add_idle(4, 3);
        add_entry(5, 1'b0, 1'b0, 1'b1, 0, 1, '0, '0, random_row());
        add_entry(5, 1'b1, 1'b0, 1'b0, 2, 0, gen_start[2][0], random_row(), '0);
        add_idle(5, 1);
        add_sweep(5, 12, 1'b0);
        add_idle(5, 3);
    endtask

    task automatic apply_entry(input stim_t s);
        expect_t e;
        active_train        = s.train;
        read_update_data    = s.read;
        is_last_layer       = s.last;
        current_input_layer = s.layer;
        current_input_row   = s.row;
        diff_start          = s.start_row;
        diff_act            = s.act_row;
        diff_cost           = s.cost_row;
        e.test  = s.test;
        e.valid = s.read;
        e.layer = m_layer;
        e.row   = m_row;
        e.grad  = s.read ? model_grad(m_layer, m_row) : '0;
        // readout walks row fastest, then layer, and restarts when the level drops
        if (s.read) begin
            if (m_row == row_idx_t'(`BP_SIZE - 1)) begin
                m_row   = '0;
                m_layer = (m_layer == layer_idx_t'(`BP_MAX_LAYERS - 1)) ? '0 : m_layer + 1'b1;
            end else begin
                m_row = m_row + 1'b1;
            end
        end else begin
            m_layer = '0;
            m_row   = '0;
        end
        if (s.train && !s.read) begin
            m_start[s.layer][s.row] = s.start_row;
            m_act[s.layer][s.row]   = s.act_row;
        end
        if (s.last) begin
            m_cost[s.row] = s.cost_row;
        end
        pending_q.push_back(e);
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_layer(input string name, input layer_idx_t got, input layer_idx_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("FAILED at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_row(input string name, input row_idx_t got, input row_idx_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("FAILED at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_value(input string name, input row_t got, input row_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_test();
        $display("test %0d %s: %s, %0d errors", cur_test, test_name[cur_test],
                 (test_errors == 0) ? "passed" : "failed", test_errors);
    endtask

    task automatic check_oldest();
        expect_t e;
        e = pending_q.pop_front();
        if (int'(e.test) != cur_test) begin
            report_test();
            cur_test    = int'(e.test);
            test_errors = 0;
        end
        check_flag("is_update_weight_o", is_update_weight, e.valid);
        if (e.valid) begin
            check_layer("update_weight_layer_o", update_weight_layer, e.layer);
            check_row("update_weight_row_o", update_weight_row, e.row);
            check_value("update_weight_value_o", update_weight_value, e.grad);
        end
    endtask

    initial begin
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not end within %0d cycles", cycle_limit);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        active_train        = 1'b0;
        read_update_data    = 1'b0;
        is_last_layer       = 1'b0;
        current_input_layer = '0;
        current_input_row   = '0;
        diff_start          = '0;
        diff_act            = '0;
        diff_cost           = '0;
        m_layer             = '0;
        m_row               = '0;
        for (int l = 0; l < `BP_MAX_LAYERS; l++) begin
            for (int r = 0; r < `BP_SIZE; r++) begin
                m_start[l][r] = '0;
                m_act[l][r]   = '0;
                m_cost[r]     = '0;
            end
        end
        test_name[1] = "idle after reset";
        test_name[2] = "store and first sweep";
        test_name[3] = "stores ignored during sweep";
        test_name[4] = "wrap and restart";
        test_name[5] = "overwrite cost and activation";
        build_stimulus();
        cycle_limit = stim_q.size() + 10 + `BP_LATENCY + 20;

        do begin
            @(negedge clk);
        end while (reset_i);

        // a request driven here shows up BP_LATENCY falling edges later
        foreach (stim_q[i]) begin
            if (pending_q.size() == `BP_LATENCY) begin
                check_oldest();
            end
            apply_entry(stim_q[i]);
            @(negedge clk);
        end
        while (pending_q.size() > 0) begin
            check_oldest();
            if (pending_q.size() > 0) begin
                @(negedge clk);
            end
        end
        report_test();

        $display("%0d tests, %0d checks, %0d errors", cur_test, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- backprop_stack.f
+incdir+include
rtl/bp_pkg.sv
rtl/update_sequencer.sv
rtl/cost_store.sv
rtl/start_store.sv
rtl/chain_multiplier.sv
rtl/gradient_accumulator.sv
rtl/backprop_stack.sv
tests/bp_clock_gen.sv
tests/backprop_stack_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module backprop_stack_tb \
    -f backprop_stack.f -o backprop_stack_sim

out=$(./obj_dir/backprop_stack_sim)
echo "$out"

if echo "$out" | grep -qx "Test OK"; then
    exit 0
fi
exit 1
